// File: Makefile
TOP := tb_reg_top

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): compile.f $(wildcard *.sv)
	verilator --binary --timing --assert --top-module $(TOP) -f compile.f -o V$(TOP)

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) > sim.log 2>&1; status=$$?; cat sim.log; exit $$status
	@if grep -q "TEST FAILED" sim.log; then exit 1; fi

lint:
	verilator --lint-only -Wall --top-module reg_top \
		reg_pkg.sv reg_arbiter.sv reg_step.sv reg_control.sv reg_file.sv reg_top.sv

clean:
	rm -rf obj_dir sim.log

// File: compile.f
reg_pkg.sv
reg_arbiter.sv
reg_step.sv
reg_control.sv
reg_file.sv
reg_top.sv
tb_reg_top.sv

// File: reg_arbiter.sv
// reg_arbiter: round-robin grant of the single register port to data channel or step unit
`default_nettype none
`timescale 1ns/1ns

module reg_arbiter (
    input  wire logic              clk,
    input  wire logic              rst_n,
    input  wire logic              dreq_valid,
    input  wire reg_pkg::reg_req_t dreq,
    output logic                   dreq_ready,
    input  wire logic              sreq_valid,
    input  wire reg_pkg::reg_req_t sreq,
    output logic                   sreq_ready,
    output logic                   gnt_valid,
    output reg_pkg::reg_req_t      gnt_req,
    output logic                   gnt_owner     // 1 = step unit
);

    logic last_step;                              // step unit served last
    logic pick_step;

    // ------------------------------
    // winner select
    // ------------------------------
    always_comb begin
        if (dreq_valid && sreq_valid)
            pick_step = !last_step;               // contention, alternate
        else
            pick_step = sreq_valid;
    end

    assign dreq_ready = dreq_valid && !pick_step;
    assign sreq_ready = sreq_valid && pick_step;
    assign gnt_valid  = dreq_valid || sreq_valid; // someone always wins
    assign gnt_req    = pick_step ? sreq : dreq;
    assign gnt_owner  = pick_step;

    // round-robin state
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            last_step <= 1'b0;                    // step wins first tie
        end else if (gnt_valid) begin
            last_step <= pick_step;
        end
    end

    // a held request that lost is granted on the next cycle
    a_data_stall: assert property (
        @(posedge clk) disable iff (!rst_n)
        (dreq_valid && !dreq_ready) |=> dreq_ready
    );

    a_step_stall: assert property (
        @(posedge clk) disable iff (!rst_n)
        (sreq_valid && !sreq_ready) |=> sreq_ready
    );

endmodule

`default_nettype wire

// File: reg_control.sv
// reg_control: exchange latches and logical-to-physical mapping of granted requests
`default_nettype none
`timescale 1ns/1ns

module reg_control (
    input  wire logic              clk,
    input  wire logic              rst_n,
    input  wire logic              gnt_valid,     // granted access this cycle
    input  wire reg_pkg::reg_req_t gnt_req,
    input  wire logic              exch_valid,
    input  wire reg_pkg::exch_op_t exch,
    output logic                   exch_ready,
    input  wire logic              step_busy,     // rmw in flight in reg_step
    output logic                   preq_valid,
    output reg_pkg::phys_req_t     preq
);

    logic       af_bank;                          // 1 = af' is live
    logic       gp_bank;                          // 1 = bc'/de'/hl' live
    logic [1:0] dehl_swap;                        // per bank de/hl swap
    logic       swapped;                          // swap bit of live bank
    logic       exch_fire;
    reg_pkg::phys_t slot;

    // ------------------------------
    // exchange latches
    // ------------------------------
    assign exch_ready = !step_busy;               // no remap under a step
    assign exch_fire  = exch_valid && exch_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            af_bank   <= 1'b0;
            gp_bank   <= 1'b0;
            dehl_swap <= 2'b00;
        end else if (exch_fire) begin
            case (exch)
                reg_pkg::EXCH_EXX:   gp_bank <= !gp_bank;
                reg_pkg::EXCH_AF:    af_bank <= !af_bank;
                reg_pkg::EXCH_DE_HL: dehl_swap[gp_bank] <= !dehl_swap[gp_bank];
                default: ;                        // reserved code, no effect
            endcase
        end
    end

    // ------------------------------
    // name to slot
    // ------------------------------
    assign swapped = dehl_swap[gp_bank];

    always_comb begin
        case (gnt_req.code)
            reg_pkg::CODE_BC: slot = {reg_pkg::P_BC[3:1], gp_bank};
            reg_pkg::CODE_DE: slot = swapped ? {reg_pkg::P_HL[3:1], gp_bank}
                                             : {reg_pkg::P_DE[3:1], gp_bank};
            reg_pkg::CODE_HL: begin
                if (gnt_req.idx == reg_pkg::IDX_IX)
                    slot = reg_pkg::P_IX;         // index regs never swap
                else if (gnt_req.idx == reg_pkg::IDX_IY)
                    slot = reg_pkg::P_IY;
                else
                    slot = swapped ? {reg_pkg::P_DE[3:1], gp_bank}
                                   : {reg_pkg::P_HL[3:1], gp_bank};
            end
            reg_pkg::CODE_AF: slot = {reg_pkg::P_AF[3:1], af_bank};
            reg_pkg::CODE_SP: slot = reg_pkg::P_SP;
            reg_pkg::CODE_WZ: slot = reg_pkg::P_WZ;
            reg_pkg::CODE_PC: slot = reg_pkg::P_PC;
            default:          slot = reg_pkg::P_IR;
        endcase
    end

    assign preq_valid   = gnt_valid;
    assign preq.write   = gnt_req.write;
    assign preq.slot    = slot;
    assign preq.byte_en = gnt_req.byte_en;
    assign preq.wdata   = gnt_req.wdata;

endmodule

`default_nettype wire

// File: reg_file.sv
// reg_file: 14 physical register pairs with byte write enables and registered read
`default_nettype none
`timescale 1ns/1ns

module reg_file (
    input  wire logic               clk,
    input  wire logic               rst_n,
    input  wire logic               preq_valid,
    input  wire reg_pkg::phys_req_t preq,
    output logic                    rsp_valid,    // one-cycle read pulse
    output reg_pkg::word_t          rsp_data
);

    reg_pkg::word_t mem [reg_pkg::N_PHYS];        // af..ir, see slot list
    logic           wr_en;
    logic           rd_en;

    assign wr_en = preq_valid && preq.write;
    assign rd_en = preq_valid && !preq.write;

    // ------------------------------
    // storage, per-byte write
    // ------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < reg_pkg::N_PHYS; i++) begin
                mem[i] <= '0;                     // all pairs come up zero
            end
        end else if (wr_en) begin
            if (preq.byte_en[1])
                mem[preq.slot][15:8] <= preq.wdata[15:8];   // high byte
            if (preq.byte_en[0])
                mem[preq.slot][7:0] <= preq.wdata[7:0];     // low byte
        end
    end

    // ------------------------------
    // read port
    // ------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= rd_en;                   // data valid next cycle
        end
    end

    always_ff @(posedge clk) begin
        if (rd_en) begin
            rsp_data <= mem[preq.slot];           // old value on same-edge write
        end
    end

    // slot encoding leaves 14 and 15 unused
    a_slot_range: assert property (
        @(posedge clk) disable iff (!rst_n)
        preq_valid |-> (preq.slot < reg_pkg::N_PHYS)
    );

endmodule

`default_nettype wire

// File: reg_pkg.sv
// widths, register and slot codes, exchange codes, request and step command structs
`default_nettype none

package reg_pkg;

    // ------------------------------
    // widths with a meaning
    // ------------------------------
    typedef logic [7:0]  byte_t;            // one register byte
    typedef logic [15:0] word_t;            // one register pair
    typedef logic [2:0]  reg_code_t;        // logical register name
    typedef logic [1:0]  idx_mode_t;        // index prefix, replaces hl
    typedef logic [3:0]  phys_t;            // physical storage slot
    typedef logic [1:0]  byte_en_t;         // bit 1 high byte, bit 0 low byte
    typedef logic [1:0]  exch_op_t;         // exchange instruction

    // logical register codes
    localparam reg_code_t CODE_BC = 3'd0;
    localparam reg_code_t CODE_DE = 3'd1;
    localparam reg_code_t CODE_HL = 3'd2;   // ix/iy under a prefix
    localparam reg_code_t CODE_AF = 3'd3;
    localparam reg_code_t CODE_SP = 3'd4;
    localparam reg_code_t CODE_WZ = 3'd5;   // internal temp pair
    localparam reg_code_t CODE_PC = 3'd6;
    localparam reg_code_t CODE_IR = 3'd7;

    // index prefix
    localparam idx_mode_t IDX_NONE = 2'd0;
    localparam idx_mode_t IDX_IX   = 2'd1;  // dd prefix
    localparam idx_mode_t IDX_IY   = 2'd2;  // fd prefix

    // ------------------------------
    // physical slots
    // ------------------------------
    // banked pairs sit on even/odd slots, bit 0 picks the shadow copy
    localparam phys_t P_AF  = 4'd0;
    localparam phys_t P_AF2 = 4'd1;
    localparam phys_t P_BC  = 4'd2;
    localparam phys_t P_BC2 = 4'd3;
    localparam phys_t P_DE  = 4'd4;
    localparam phys_t P_DE2 = 4'd5;
    localparam phys_t P_HL  = 4'd6;
    localparam phys_t P_HL2 = 4'd7;
    localparam phys_t P_IX  = 4'd8;
    localparam phys_t P_IY  = 4'd9;
    localparam phys_t P_SP  = 4'd10;
    localparam phys_t P_WZ  = 4'd11;
    localparam phys_t P_PC  = 4'd12;
    localparam phys_t P_IR  = 4'd13;
    localparam int    N_PHYS = 14;          // slots actually stored

    // exchange codes
    localparam exch_op_t EXCH_EXX   = 2'd0; // bc/de/hl bank flip
    localparam exch_op_t EXCH_AF    = 2'd1; // ex af,af'
    localparam exch_op_t EXCH_DE_HL = 2'd2; // ex de,hl in current bank

    // ------------------------------
    // structs
    // ------------------------------
    typedef struct packed {
        logic      write;                   // 1 write, 0 read
        reg_code_t code;
        idx_mode_t idx;
        byte_en_t  byte_en;
        word_t     wdata;
    } reg_req_t;                            // logical access

    typedef struct packed {
        logic     write;
        phys_t    slot;                     // after exchange/index steering
        byte_en_t byte_en;
        word_t    wdata;
    } phys_req_t;                           // mapped access

    typedef struct packed {
        reg_code_t code;
        idx_mode_t idx;
        logic      dec;                     // 1 subtract one
    } step_cmd_t;

endpackage

`default_nettype wire

// File: reg_step.sv
// reg_step: read-modify-write FSM that increments or decrements one register pair
`default_nettype none
`timescale 1ns/1ns

module reg_step (
    input  wire logic               clk,
    input  wire logic               rst_n,
    input  wire logic               step_valid,
    input  wire reg_pkg::step_cmd_t step,
    output logic                    step_ready,
    output logic                    sreq_valid,
    output reg_pkg::reg_req_t       sreq,
    input  wire logic               sreq_ready,
    input  wire logic               rsp_valid,    // routed read return
    input  wire reg_pkg::word_t     rsp_data,
    output logic                    busy,
    output logic                    step_done,
    output reg_pkg::word_t          step_result
);

    typedef enum logic [2:0] {IDLE, RD_REQ, RD_WAIT, WR_REQ, DONE} state_t;

    state_t             state;
    reg_pkg::step_cmd_t cmd;                      // held for both accesses
    reg_pkg::word_t     result;                   // new pair value

    // ------------------------------
    // FSM
    // ------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE:    if (step_valid) state <= RD_REQ;
                RD_REQ:  if (sreq_ready) state <= RD_WAIT;
                RD_WAIT: if (rsp_valid)  state <= WR_REQ;
                WR_REQ:  if (sreq_ready) state <= DONE;
                default: state <= IDLE;           // DONE lasts one cycle
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE && step_valid)
            cmd <= step;
        if (state == RD_WAIT && rsp_valid)
            result <= cmd.dec ? rsp_data - 16'd1 : rsp_data + 16'd1;  // wraps
    end

    assign step_ready  = (state == IDLE);
    assign busy        = (state != IDLE);
    assign step_done   = (state == DONE);
    assign step_result = result;

    // request toward arbiter, read then full-word write
    assign sreq_valid   = (state == RD_REQ) || (state == WR_REQ);
    assign sreq.write   = (state == WR_REQ);
    assign sreq.code    = cmd.code;
    assign sreq.idx     = cmd.idx;
    assign sreq.byte_en = 2'b11;
    assign sreq.wdata   = result;

    // top-level owner routing must only return our own reads
    a_rsp_in_wait: assert property (
        @(posedge clk) disable iff (!rst_n)
        rsp_valid |-> (state == RD_WAIT)
    );

endmodule

`default_nettype wire

// File: reg_top.sv
// reg_top: arbiter, step unit, exchange control and register file with response routing
`default_nettype none
`timescale 1ns/1ns

module reg_top (
    input  wire logic               clk,
    input  wire logic               rst_n,
    input  wire logic               dreq_valid,
    input  wire reg_pkg::reg_req_t  dreq,
    output logic                    dreq_ready,
    output logic                    drsp_valid,
    output reg_pkg::word_t          drsp_data,
    input  wire logic               step_valid,
    input  wire reg_pkg::step_cmd_t step,
    output logic                    step_ready,
    output logic                    step_done,
    output reg_pkg::word_t          step_result,
    input  wire logic               exch_valid,
    input  wire reg_pkg::exch_op_t  exch,
    output logic                    exch_ready
);

    logic               sreq_valid;
    logic               sreq_ready;
    reg_pkg::reg_req_t  sreq;
    logic               gnt_valid;
    logic               gnt_owner;
    reg_pkg::reg_req_t  gnt_req;
    logic               preq_valid;
    reg_pkg::phys_req_t preq;
    logic               rsp_valid;
    reg_pkg::word_t     rsp_data;
    logic               step_busy;
    logic               owner_q;                  // owner of last grant

    // ------------------------------
    // shared return path
    // ------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            owner_q <= 1'b0;
        end else begin
            owner_q <= gnt_owner;                 // lines up with rsp_valid
        end
    end

    assign drsp_valid = rsp_valid && !owner_q;
    assign drsp_data  = rsp_data;

    reg_arbiter i_reg_arbiter (
        .clk(clk), .rst_n(rst_n),
        .dreq_valid(dreq_valid), .dreq(dreq), .dreq_ready(dreq_ready),
        .sreq_valid(sreq_valid), .sreq(sreq), .sreq_ready(sreq_ready),
        .gnt_valid(gnt_valid), .gnt_req(gnt_req), .gnt_owner(gnt_owner)
    );

    reg_step i_reg_step (
        .clk(clk), .rst_n(rst_n),
        .step_valid(step_valid), .step(step), .step_ready(step_ready),
        .sreq_valid(sreq_valid), .sreq(sreq), .sreq_ready(sreq_ready),
        .rsp_valid(rsp_valid && owner_q), .rsp_data(rsp_data),
        .busy(step_busy), .step_done(step_done), .step_result(step_result)
    );

    reg_control i_reg_control (
        .clk(clk), .rst_n(rst_n),
        .gnt_valid(gnt_valid), .gnt_req(gnt_req),
        .exch_valid(exch_valid), .exch(exch), .exch_ready(exch_ready),
        .step_busy(step_busy),
        .preq_valid(preq_valid), .preq(preq)
    );

    reg_file i_reg_file (
        .clk(clk), .rst_n(rst_n),
        .preq_valid(preq_valid), .preq(preq),
        .rsp_valid(rsp_valid), .rsp_data(rsp_data)
    );

endmodule

`default_nettype wire

// File: tb_reg_top.sv
// tb_reg_top: random testbench with logical register model, LFSR stimulus, watchdog and report
`default_nettype none
`timescale 1ns/1ns

module tb_reg_top;

    localparam int CLK_PERIOD = 40;
    localparam int N_SWEEP = 24;                  // 8 codes x 3 index modes
    localparam int N_DATA  = 200;
    localparam int N_EXCH  = 300;
    localparam int N_STEP  = 60;
    localparam int N_MIX   = 300;
    localparam int N_TOTAL = 2 * N_SWEEP + N_DATA + N_EXCH + N_STEP + N_MIX;

    localparam int M_SWEEP = 0;                   // read every code and index mode
    localparam int M_DATA  = 1;                   // random writes and reads
    localparam int M_EXCH  = 2;                   // same, plus exchanges
    localparam int M_STEP  = 3;                   // steps and exchanges only
    localparam int M_MIX   = 4;                   // data, steps and exchanges together

    logic               clk;
    logic               rst_n;
    logic               dreq_valid;
    reg_pkg::reg_req_t  dreq;
    logic               dreq_ready;
    logic               drsp_valid;
    reg_pkg::word_t     drsp_data;
    logic               step_valid;
    reg_pkg::step_cmd_t step;
    logic               step_ready;
    logic               step_done;
    reg_pkg::word_t     step_result;
    logic               exch_valid;
    reg_pkg::exch_op_t  exch;
    logic               exch_ready;

    logic [15:0]        lfsr;
    reg_pkg::word_t     model [14];               // 0..7 by code, 8 ix, 9 iy, 10..13 shadows
    reg_pkg::word_t     rd_q [$];                 // expected read data, request order
    int                 chk_cnt;
    int                 err_cnt;

    reg_top i_reg_top (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ------------------------------
    // random source and reporting
    // ------------------------------
    function automatic logic [15:0] rnd(input int nbits);
        logic [15:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < nbits; i++) begin
            fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];   // x^16+x^14+x^13+x^11+1
            lfsr = {lfsr[14:0], fb};
            v = {v[14:0], fb};
        end
        return v;
    endfunction

    function automatic reg_pkg::idx_mode_t idx_pick();
        reg_pkg::idx_mode_t v;
        v = 2'(rnd(2));
        return (v == 2'd3) ? reg_pkg::IDX_NONE : v;   // only three prefixes
    endfunction

    task automatic report_mismatch(input string sig, input logic [15:0] exp,
                                   input logic [15:0] got);
        $display("FAILED %s expected %h got %h at %0t", sig, exp, got, $time);
        err_cnt++;
    endtask

    task automatic report_error(input string msg);
        $display("error: %s at %0t", msg, $time);
        err_cnt++;
    endtask

    // ------------------------------
    // logical register model
    // ------------------------------
    function automatic int lidx(input reg_pkg::reg_code_t code, input reg_pkg::idx_mode_t idx);
        if (code == reg_pkg::CODE_HL && idx == reg_pkg::IDX_IX)
            return 8;
        if (code == reg_pkg::CODE_HL && idx == reg_pkg::IDX_IY)
            return 9;
        return int'(code);
    endfunction

    task automatic swap_model(input int a, input int b);
        reg_pkg::word_t t;
        t = model[a];
        model[a] = model[b];
        model[b] = t;
    endtask

    task automatic apply_exch(input reg_pkg::exch_op_t op);
        case (op)
            reg_pkg::EXCH_EXX: begin
                swap_model(0, 10);                // bc, de, hl with their shadows
                swap_model(1, 11);
                swap_model(2, 12);
            end
            reg_pkg::EXCH_AF: swap_model(3, 13);
            default:          swap_model(1, 2);   // de <-> hl of live bank
        endcase
    endtask

    // ------------------------------
    // per-cycle driver and checker
    // ------------------------------
    task automatic run_phase(input int mode, input int n_ops, input string name);
        int             issued;
        int             d_cnt;
        int             errs0;
        int             li;
        int             s_li;
        logic           d_fire;
        logic           s_fire;
        logic           x_fire;
        logic           s_fly;
        logic           rd_due;
        reg_pkg::word_t s_exp;
        issued = 0;
        d_cnt  = 0;
        errs0  = err_cnt;
        d_fire = 1'b0;
        s_fire = 1'b0;
        x_fire = 1'b0;
        s_fly  = 1'b0;
        rd_due = 1'b0;
        s_li   = 0;
        s_exp  = '0;
        do begin
            @(negedge clk);
            if (d_fire) dreq_valid = 1'b0;
            if (s_fire) step_valid = 1'b0;
            if (x_fire) exch_valid = 1'b0;
            if (!dreq_valid && issued < n_ops && mode != M_STEP &&
                (mode == M_SWEEP || rnd(2) != 16'd0)) begin
                dreq.write   = (mode != M_SWEEP) && rnd(1) == 16'd1;
                dreq.code    = (mode == M_SWEEP) ? d_cnt[2:0] :
                               (mode == M_MIX)   ? {1'b0, 2'(rnd(2))} : 3'(rnd(3));
                dreq.idx     = (mode == M_SWEEP) ? 2'(d_cnt / 8) : idx_pick();
                dreq.byte_en = 2'(rnd(2));
                dreq.wdata   = rnd(16);
                dreq_valid   = 1'b1;
                d_cnt++;
                issued++;
            end
            if (!step_valid && !s_fly && issued < n_ops && mode >= M_STEP &&
                rnd(2) == 16'd0) begin
                step.code  = (mode == M_MIX) ? {1'b1, 2'(rnd(2))} : 3'(rnd(3));  // sp..ir under mix
                step.idx   = idx_pick();
                step.dec   = rnd(1) == 16'd1;
                step_valid = 1'b1;
                issued++;
            end
            if (!exch_valid && issued < n_ops && mode >= M_EXCH && rnd(3) == 16'd0) begin
                exch = 2'(rnd(2));
                if (exch == 2'd3)
                    exch = reg_pkg::EXCH_DE_HL;
                exch_valid = 1'b1;
                issued++;
            end
            #10;                                  // sample mid low phase
            d_fire = dreq_valid && dreq_ready;
            s_fire = step_valid && step_ready;
            x_fire = exch_valid && exch_ready;
            chk_cnt++;
            // step unit idle only when no step is in flight
            if (step_ready !== !s_fly)
                report_mismatch("step_ready", 16'(!s_fly), 16'(step_ready));
            if (exch_ready !== !s_fly)
                report_mismatch("exch_ready", 16'(!s_fly), 16'(exch_ready));
            if (drsp_valid !== rd_due)
                report_mismatch("drsp_valid", 16'(rd_due), 16'(drsp_valid));
            if (drsp_valid) begin
                if (rd_q.size() == 0) begin
                    report_error("drsp_valid with no data read outstanding");
                end else begin
                    chk_cnt++;
                    if (drsp_data !== rd_q[0])
                        report_mismatch("drsp_data", rd_q[0], drsp_data);
                    void'(rd_q.pop_front());
                end
            end
            if (step_done) begin
                if (!s_fly) begin
                    report_error("step_done without an accepted step command");
                end else begin
                    chk_cnt++;
                    if (step_result !== s_exp)
                        report_mismatch("step_result", s_exp, step_result);
                    model[s_li] = s_exp;
                    s_fly = 1'b0;
                end
            end
            // same edge: data op maps before the exchange, step reads after it
            if (d_fire) begin
                li = lidx(dreq.code, dreq.idx);
                if (dreq.write)
                    model[li] = {dreq.byte_en[1] ? dreq.wdata[15:8] : model[li][15:8],
                                 dreq.byte_en[0] ? dreq.wdata[7:0]  : model[li][7:0]};
                else
                    rd_q.push_back(model[li]);
            end
            rd_due = d_fire && !dreq.write;       // response due next cycle
            if (x_fire)
                apply_exch(exch);
            if (s_fire) begin
                s_li  = lidx(step.code, step.idx);
                s_exp = step.dec ? model[s_li] - 16'd1 : model[s_li] + 16'd1;
                s_fly = 1'b1;
            end
        end while (issued < n_ops || dreq_valid || step_valid || exch_valid || s_fly ||
                   rd_q.size() != 0);
        $display("%-22s %0d ops, %0d errors", name, n_ops, err_cnt - errs0);
    endtask

    // ------------------------------
    // main sequence and watchdog
    // ------------------------------
    initial begin
        lfsr       = 16'd62;
        chk_cnt    = 0;
        err_cnt    = 0;
        for (int i = 0; i < 14; i++)
            model[i] = '0;
        rst_n      = 1'b0;
        dreq_valid = 1'b0;
        dreq       = '0;
        step_valid = 1'b0;
        step       = '0;
        exch_valid = 1'b0;
        exch       = '0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        #10;
        chk_cnt++;
        if (dreq_ready || drsp_valid || step_done || !step_ready || !exch_ready)
            report_error("outputs not at their reset values");
        run_phase(M_SWEEP, N_SWEEP, "reset values");
        run_phase(M_DATA,  N_DATA,  "word and byte writes");
        run_phase(M_EXCH,  N_EXCH,  "exchanges and index");
        run_phase(M_STEP,  N_STEP,  "step commands");
        run_phase(M_MIX,   N_MIX,   "concurrent traffic");
        run_phase(M_SWEEP, N_SWEEP, "final readback");
        $display("checks %0d, errors %0d", chk_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    initial begin
        #(N_TOTAL * 20 * CLK_PERIOD);
        $display("watchdog: run did not finish within %0d cycles", N_TOTAL * 20);
        $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire
